/* verification/mont_stim.txt */
// Columns: a, b, tag, expected a*b*R^-1 mod 251 with R = 1024
// All values in hex, one vector per line
0000 0000 0001 0000
0000 00fa 0002 0000
0001 0001 0003 0071
0001 00fa 0004 008a
00fa 00fa 0005 0071
0014 0007 0006 0007
0014 00fa 0007 00fa
0014 0000 0008 0000
0002 0003 0009 00b0
0064 00c8 000a 00f7
007b 002d 000b 00d6
00fa 0001 000c 008a
0011 0013 000d 0068
00c8 00c8 000e 00f3
0007 0014 000f 0007
0080 0040 0010 0008
0063 009b 0011 004d
00f9 00f8 0012 00b0

/* list.f */
hdl/mont_pkg.sv
hdl/stream_fifo.sv
hdl/stream_mult.sv
hdl/stream_addsub.sv
hdl/montgomery_mult.sv
hdl/mont_mult_top.sv
verification/tb_mont_mult_top.sv

/* Bender.yml */
package:
  name: mont_mult

sources:
  - hdl/mont_pkg.sv
  - hdl/stream_fifo.sv
  - hdl/stream_mult.sv
  - hdl/stream_addsub.sv
  - hdl/montgomery_mult.sv
  - hdl/mont_mult_top.sv
  - target: test
    files:
      - verification/tb_mont_mult_top.sv

/* verification/tb_mont_mult_top.sv */
//====================================================================
// Montgomery multiplier testbench
// Streams vectors from the stim file, first without and then with
// output back-pressure, and checks results, tags, order and latency
//====================================================================
`timescale 1ns/1ps

module tb_mont_mult_top;

  localparam int NUM_VEC     = 18;
  localparam int LATENCY     = 17;
  localparam int MODULUS     = 251;
  localparam int WAIT_LIMIT  = 200;
  localparam int DRAIN_LIMIT = 2000;

  logic        i_clk;
  logic        i_rst;
  logic        i_val;
  logic [15:0] i_a;
  logic [15:0] i_b;
  logic [7:0]  i_ctl;
  logic        i_rdy = 1'b1;
  logic        o_rdy;
  logic        o_val;
  logic [15:0] o_dat;
  logic [7:0]  o_ctl;

  // Four words per vector as a, b, tag and expected
  logic [15:0] stim_mem [0:4*NUM_VEC-1];

  integer      seed = 31561;
  integer      rnd;
  logic        backpressure = 1'b0;
  int          drive_idx;
  int          cycle = 0;
  int          errors = 0;
  int          out_count = 0;
  int          stall_cycles = 0;
  int          max_in_flight = 0;
  logic        held_valid = 1'b0;
  logic [15:0] held_dat;
  logic [7:0]  held_ctl;

  // Items accepted but not yet seen on the output
  int          pend_idx [$];
  logic [7:0]  pend_ctl [$];
  int          pend_cycle [$];
  bit          pend_timed [$];

  mont_mult_top u_mont_mult_top (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_val (i_val),
    .i_a   (i_a),
    .i_b   (i_b),
    .i_ctl (i_ctl),
    .o_rdy (o_rdy),
    .o_val (o_val),
    .o_dat (o_dat),
    .o_ctl (o_ctl),
    .i_rdy (i_rdy)
  );

  always #4 i_clk = ~i_clk;

  // Random sink is ready about three cycles out of four
  always @(posedge i_clk) begin
    if (backpressure) begin
      rnd = $random(seed);
      i_rdy <= rnd[0] | rnd[1];
    end else begin
      i_rdy <= 1'b1;
    end
  end

  task automatic print_counts();
    $display("Summary: %0d outputs, %0d stalled cycles, %0d errors",
             out_count, stall_cycles, errors);
  endtask

  task automatic abort_run(input string reason);
    errors++;
    $display("Run aborted: %s", reason);
    print_counts();
    $display("Simulation failed");
    $finish;
  endtask

  task automatic check_output();
    int         idx;
    logic [7:0] tag;
    int         t0;
    bit         timed;
    logic [15:0] want;
    out_count++;
    if (pend_idx.size() == 0) begin
      errors++;
      $display("Unexpected output with tag %02h while no item was in flight", o_ctl);
    end else begin
      idx   = pend_idx.pop_front();
      tag   = pend_ctl.pop_front();
      t0    = pend_cycle.pop_front();
      timed = pend_timed.pop_front();
      want  = stim_mem[4*idx+3];
      assert (o_dat == want) else begin
        errors++;
        $display("[FAIL] %0t: vector %0d result %0d, expected %0d", $time, idx, o_dat, want);
      end
      assert (o_dat < MODULUS) else begin
        errors++;
        $display("[FAIL] %0t: vector %0d result %0d not below P", $time, idx, o_dat);
      end
      assert (o_ctl == tag) else begin
        errors++;
        $display("[FAIL] %0t: tag %02h, expected %02h", $time, o_ctl, tag);
      end
      if (timed) begin
        assert (cycle - t0 == LATENCY) else begin
          errors++;
          $display("[FAIL] %0t: vector %0d latency %0d, expected %0d",
                   $time, idx, cycle - t0, LATENCY);
        end
      end
    end
  endtask

  // Monitor samples on the rising edge before the DUT updates
  always @(posedge i_clk) begin
    cycle++;
    if (!i_rst) begin
      if (held_valid) begin
        assert (o_val && o_dat == held_dat && o_ctl == held_ctl) else begin
          errors++;
          $display("[FAIL] %0t: stalled output changed from %0d/%02h to %0d/%02h",
                   $time, held_dat, held_ctl, o_dat, o_ctl);
        end
      end
      held_valid = o_val && !i_rdy;
      held_dat   = o_dat;
      held_ctl   = o_ctl;
      if (held_valid) begin
        stall_cycles++;
      end
      if (o_val && i_rdy) begin
        check_output();
      end
      if (i_val && o_rdy) begin
        pend_idx.push_back(drive_idx);
        pend_ctl.push_back(i_ctl);
        pend_cycle.push_back(cycle);
        pend_timed.push_back(!backpressure);
        if (pend_idx.size() > max_in_flight) begin
          max_in_flight = pend_idx.size();
        end
      end
    end
  end

  // Starts right after a rising edge and returns on the accepting edge
  task automatic send_item(input int idx, input logic [7:0] tag_flip);
    bit accepted;
    i_val     <= 1'b1;
    i_a       <= stim_mem[4*idx];
    i_b       <= stim_mem[4*idx+1];
    i_ctl     <= stim_mem[4*idx+2][7:0] ^ tag_flip;
    drive_idx <= idx;
    accepted = 1'b0;
    for (int w = 0; w < WAIT_LIMIT && !accepted; w++) begin
      @(posedge i_clk);
      accepted = o_rdy;
    end
    if (!accepted) begin
      abort_run("an input was never accepted because o_rdy stayed low");
    end
  endtask

  task automatic wait_for_drain(input int total);
    bit done;
    done = 1'b0;
    for (int w = 0; w < DRAIN_LIMIT && !done; w++) begin
      @(negedge i_clk);
      done = (out_count >= total) && (pend_idx.size() == 0);
    end
    if (!done) begin
      abort_run("the pipeline did not return all results in time");
    end
  endtask

  initial begin
    i_clk     = 1'b0;
    i_rst     = 1'b1;
    i_val     = 1'b0;
    i_a       = '0;
    i_b       = '0;
    i_ctl     = '0;
    drive_idx = 0;
    $readmemh("verification/mont_stim.txt", stim_mem);
    if ($isunknown(stim_mem[4*NUM_VEC-1])) begin
      abort_run("the stimulus file could not be read completely");
    end

    repeat (3) @(posedge i_clk);
    i_rst <= 1'b0;
    @(negedge i_clk);
    assert (!o_val && o_rdy) else begin
      errors++;
      $display("[FAIL] %0t: after reset o_val=%0b o_rdy=%0b", $time, o_val, o_rdy);
    end

    // Back-to-back with the sink always ready
    @(posedge i_clk);
    for (int n = 0; n < NUM_VEC; n++) begin
      send_item(n, 8'h00);
    end
    i_val <= 1'b0;
    wait_for_drain(NUM_VEC);
    assert (max_in_flight >= 4) else begin
      errors++;
      $display("Only %0d items were in flight at once", max_in_flight);
    end

    // Same vectors again with flipped tags and a random sink
    backpressure <= 1'b1;
    @(posedge i_clk);
    for (int n = 0; n < NUM_VEC; n++) begin
      send_item(n, 8'h80);
    end
    i_val <= 1'b0;
    wait_for_drain(2 * NUM_VEC);

    // Idle time to catch stray or repeated outputs
    repeat (20) @(posedge i_clk);
    @(negedge i_clk);
    assert (out_count == 2 * NUM_VEC) else begin
      errors++;
      $display("Output count %0d does not match %0d inputs", out_count, 2 * NUM_VEC);
    end
    assert (stall_cycles > 0) else begin
      errors++;
      $display("Back-pressure never stalled the output");
    end

    print_counts();
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* hdl/mont_mult_top.sv */
//====================================================================
// Montgomery multiplier top level
// Sequencer wired to three multipliers, an adder and a subtractor
//====================================================================
`timescale 1ns/1ps

module mont_mult_top (
  input  logic                          i_clk,
  input  logic                          i_rst,
  input  logic                          i_val,
  input  logic [mont_pkg::DAT_BITS-1:0] i_a,
  input  logic [mont_pkg::DAT_BITS-1:0] i_b,
  input  logic [mont_pkg::CTL_BITS-1:0] i_ctl,
  output logic                          o_rdy,
  output logic                          o_val,
  output logic [mont_pkg::DAT_BITS-1:0] o_dat,
  output logic [mont_pkg::CTL_BITS-1:0] o_ctl,
  input  logic                          i_rdy
);
  import mont_pkg::*;

  // Requests from the sequencer
  logic                   m0_req_val, m1_req_val, m2_req_val, add_req_val, sub_req_val;
  logic                   m0_req_rdy, m1_req_rdy, m2_req_rdy, add_req_rdy, sub_req_rdy;
  logic [PROD_BITS-1:0]   m0_req_dat, m1_req_dat, m2_req_dat;
  logic [2*PROD_BITS-1:0] add_req_dat, sub_req_dat;
  logic [CTL_BITS-1:0]    m0_req_ctl, m1_req_ctl, m2_req_ctl, add_req_ctl, sub_req_ctl;
  // Responses back to it
  logic                   m0_rsp_val, m1_rsp_val, m2_rsp_val, add_rsp_val, sub_rsp_val;
  logic                   m0_rsp_rdy, m1_rsp_rdy, m2_rsp_rdy, add_rsp_rdy, sub_rsp_rdy;
  logic [PROD_BITS-1:0]   m0_rsp_dat, m1_rsp_dat, m2_rsp_dat, add_rsp_dat, sub_rsp_dat;
  logic [CTL_BITS-1:0]    m0_rsp_ctl, m1_rsp_ctl, m2_rsp_ctl, add_rsp_ctl, sub_rsp_ctl;

  montgomery_mult u_montgomery_mult (
    .i_clk      (i_clk),       .i_rst      (i_rst),
    .i_val      (i_val),       .i_dat      ({i_b, i_a}),
    .i_ctl      (i_ctl),       .o_rdy      (o_rdy),
    .o_val      (o_val),       .o_dat      (o_dat),
    .o_ctl      (o_ctl),       .i_rdy      (i_rdy),
    .o_mul0_val (m0_req_val),  .o_mul0_dat (m0_req_dat),
    .o_mul0_ctl (m0_req_ctl),  .i_mul0_rdy (m0_req_rdy),
    .o_mul1_val (m1_req_val),  .o_mul1_dat (m1_req_dat),
    .o_mul1_ctl (m1_req_ctl),  .i_mul1_rdy (m1_req_rdy),
    .o_mul2_val (m2_req_val),  .o_mul2_dat (m2_req_dat),
    .o_mul2_ctl (m2_req_ctl),  .i_mul2_rdy (m2_req_rdy),
    .o_add_val  (add_req_val), .o_add_dat  (add_req_dat),
    .o_add_ctl  (add_req_ctl), .i_add_rdy  (add_req_rdy),
    .o_sub_val  (sub_req_val), .o_sub_dat  (sub_req_dat),
    .o_sub_ctl  (sub_req_ctl), .i_sub_rdy  (sub_req_rdy),
    .i_mul0_val (m0_rsp_val),  .i_mul0_dat (m0_rsp_dat),
    .i_mul0_ctl (m0_rsp_ctl),  .o_mul0_rdy (m0_rsp_rdy),
    .i_mul1_val (m1_rsp_val),  .i_mul1_dat (m1_rsp_dat),
    .i_mul1_ctl (m1_rsp_ctl),  .o_mul1_rdy (m1_rsp_rdy),
    .i_mul2_val (m2_rsp_val),  .i_mul2_dat (m2_rsp_dat),
    .i_mul2_ctl (m2_rsp_ctl),  .o_mul2_rdy (m2_rsp_rdy),
    .i_add_val  (add_rsp_val), .i_add_dat  (add_rsp_dat),
    .i_add_ctl  (add_rsp_ctl), .o_add_rdy  (add_rsp_rdy),
    .i_sub_val  (sub_rsp_val), .i_sub_dat  (sub_rsp_dat),
    .i_sub_ctl  (sub_rsp_ctl), .o_sub_rdy  (sub_rsp_rdy)
  );

  // a*b = T
  stream_mult u_mul0 (
    .i_clk (i_clk),      .i_rst (i_rst),
    .i_val (m0_req_val), .i_dat (m0_req_dat), .i_ctl (m0_req_ctl), .o_rdy (m0_req_rdy),
    .o_val (m0_rsp_val), .o_dat (m0_rsp_dat), .o_ctl (m0_rsp_ctl), .i_rdy (m0_rsp_rdy)
  );

  // (T mod R) * factor = m
  stream_mult u_mul1 (
    .i_clk (i_clk),      .i_rst (i_rst),
    .i_val (m1_req_val), .i_dat (m1_req_dat), .i_ctl (m1_req_ctl), .o_rdy (m1_req_rdy),
    .o_val (m1_rsp_val), .o_dat (m1_rsp_dat), .o_ctl (m1_rsp_ctl), .i_rdy (m1_rsp_rdy)
  );

  // (m mod R) * P
  stream_mult u_mul2 (
    .i_clk (i_clk),      .i_rst (i_rst),
    .i_val (m2_req_val), .i_dat (m2_req_dat), .i_ctl (m2_req_ctl), .o_rdy (m2_req_rdy),
    .o_val (m2_rsp_val), .o_dat (m2_rsp_dat), .o_ctl (m2_rsp_ctl), .i_rdy (m2_rsp_rdy)
  );

  stream_addsub #(
    .OP (OP_ADD)
  ) u_add (
    .i_clk (i_clk),       .i_rst (i_rst),
    .i_val (add_req_val), .i_dat (add_req_dat), .i_ctl (add_req_ctl), .o_rdy (add_req_rdy),
    .o_val (add_rsp_val), .o_dat (add_rsp_dat), .o_ctl (add_rsp_ctl), .i_rdy (add_rsp_rdy)
  );

  stream_addsub #(
    .OP (OP_CSUB)
  ) u_csub (
    .i_clk (i_clk),       .i_rst (i_rst),
    .i_val (sub_req_val), .i_dat (sub_req_dat), .i_ctl (sub_req_ctl), .o_rdy (sub_req_rdy),
    .o_val (sub_rsp_val), .o_dat (sub_rsp_dat), .o_ctl (sub_rsp_ctl), .i_rdy (sub_rsp_rdy)
  );

endmodule

/* hdl/montgomery_mult.sv */
//====================================================================
// Montgomery multiplication sequencer
// Six registered stages computing a*b*R^-1 mod P with external units,
// T waits in a FIFO until mP comes back
//====================================================================
`timescale 1ns/1ps

module montgomery_mult (
  input  logic                             i_clk,
  input  logic                             i_rst,
  // Operand stream, {b, a}
  input  logic                             i_val,
  input  logic [mont_pkg::PROD_BITS-1:0]   i_dat,
  input  logic [mont_pkg::CTL_BITS-1:0]    i_ctl,
  output logic                             o_rdy,
  // Reduced result stream
  output logic                             o_val,
  output logic [mont_pkg::DAT_BITS-1:0]    o_dat,
  output logic [mont_pkg::CTL_BITS-1:0]    o_ctl,
  input  logic                             i_rdy,
  // Requests to the multipliers, adder and subtractor
  output logic                             o_mul0_val, o_mul1_val, o_mul2_val,
  output logic                             o_add_val, o_sub_val,
  output logic [mont_pkg::PROD_BITS-1:0]   o_mul0_dat, o_mul1_dat, o_mul2_dat,
  output logic [2*mont_pkg::PROD_BITS-1:0] o_add_dat, o_sub_dat,
  output logic [mont_pkg::CTL_BITS-1:0]    o_mul0_ctl, o_mul1_ctl, o_mul2_ctl,
  output logic [mont_pkg::CTL_BITS-1:0]    o_add_ctl, o_sub_ctl,
  input  logic                             i_mul0_rdy, i_mul1_rdy, i_mul2_rdy,
  input  logic                             i_add_rdy, i_sub_rdy,
  // Results returning from the units
  input  logic                             i_mul0_val, i_mul1_val, i_mul2_val,
  input  logic                             i_add_val, i_sub_val,
  input  logic [mont_pkg::PROD_BITS-1:0]   i_mul0_dat, i_mul1_dat, i_mul2_dat,
  input  logic [mont_pkg::PROD_BITS-1:0]   i_add_dat, i_sub_dat,
  input  logic [mont_pkg::CTL_BITS-1:0]    i_mul0_ctl, i_mul1_ctl, i_mul2_ctl,
  input  logic [mont_pkg::CTL_BITS-1:0]    i_add_ctl, i_sub_ctl,
  output logic                             o_mul0_rdy, o_mul1_rdy, o_mul2_rdy,
  output logic                             o_add_rdy, o_sub_rdy
);
  import mont_pkg::*;

  logic                 fifo_in_val;
  logic                 fifo_in_rdy;
  logic                 fifo_out_val;
  logic [PROD_BITS-1:0] fifo_out_dat;
  logic [CTL_BITS-1:0]  fifo_out_ctl;
  logic                 fifo_out_rdy;
  logic                 fifo_full;
  logic                 s2_free;
  logic                 s4_free;

  // Stage 1: operands to multiplier 0
  assign o_rdy = ~o_mul0_val || i_mul0_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_mul0_val <= 1'b0;
    end else if (o_rdy) begin
      o_mul0_val <= i_val;
      o_mul0_dat <= i_dat;
      o_mul0_ctl <= i_ctl;
    end
  end

  // Stage 2: T mod R times factor, T itself into the FIFO
  assign s2_free     = ~o_mul1_val || i_mul1_rdy;
  assign o_mul0_rdy  = s2_free && fifo_in_rdy;
  assign fifo_in_val = i_mul0_val && s2_free;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_mul1_val <= 1'b0;
    end else if (s2_free) begin
      o_mul1_val <= i_mul0_val && fifo_in_rdy;
      o_mul1_dat <= {MONT_FACTOR, i_mul0_dat[DAT_BITS-1:0] & RED_MASK};
      o_mul1_ctl <= i_mul0_ctl;
    end
  end

  // Stage 3: m mod R times P
  assign o_mul1_rdy = ~o_mul2_val || i_mul2_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_mul2_val <= 1'b0;
    end else if (o_mul1_rdy) begin
      o_mul2_val <= i_mul1_val;
      o_mul2_dat <= {MOD_P, i_mul1_dat[DAT_BITS-1:0] & RED_MASK};
      o_mul2_ctl <= i_mul1_ctl;
    end
  end

  // Stage 4: join mP with the stored T
  assign s4_free      = ~o_add_val || i_add_rdy;
  assign o_mul2_rdy   = s4_free && fifo_out_val;
  assign fifo_out_rdy = s4_free && i_mul2_val;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_add_val <= 1'b0;
    end else if (s4_free) begin
      o_add_val <= i_mul2_val && fifo_out_val;
      o_add_dat <= {fifo_out_dat, i_mul2_dat};
      o_add_ctl <= i_mul2_ctl;
    end
  end

  // Stage 5: divide by R, then compare against P
  assign o_add_rdy = ~o_sub_val || i_sub_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_sub_val <= 1'b0;
    end else if (o_add_rdy) begin
      o_sub_val <= i_add_val;
      o_sub_dat <= {PROD_BITS'(MOD_P), i_add_dat >> REDUCE_BITS};
      o_sub_ctl <= i_add_ctl;
    end
  end

  // Stage 6: output register
  assign o_sub_rdy = ~o_val || i_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
    end else if (o_sub_rdy) begin
      o_val <= i_sub_val;
      o_dat <= i_sub_dat[DAT_BITS-1:0];
      o_ctl <= i_sub_ctl;
    end
  end

  stream_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) u_t_fifo (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .i_val  (fifo_in_val),
    .i_dat  (i_mul0_dat),
    .i_ctl  (i_mul0_ctl),
    .o_rdy  (fifo_in_rdy),
    .o_val  (fifo_out_val),
    .o_dat  (fifo_out_dat),
    .o_ctl  (fifo_out_ctl),
    .i_rdy  (fifo_out_rdy),
    .o_full (fifo_full)
  );

  // mP meets the T stored for the same item
  assert property (@(posedge i_clk) disable iff (i_rst)
    i_mul2_val && fifo_out_val && s4_free |-> i_mul2_ctl == fifo_out_ctl);

  // Items between write and join never exceed the buffer
  assert property (@(posedge i_clk) disable iff (i_rst) !fifo_full);

endmodule

/* hdl/stream_addsub.sv */
//====================================================================
// Stream add / conditional subtract
// One registered stage: lo + hi, or lo - hi when lo is not below hi
//====================================================================
`timescale 1ns/1ps

module stream_addsub #(
  parameter mont_pkg::addsub_op_t OP = mont_pkg::OP_ADD
) (
  input  logic                             i_clk,
  input  logic                             i_rst,
  // Two operands packed as {hi, lo}
  input  logic                             i_val,
  input  logic [2*mont_pkg::PROD_BITS-1:0] i_dat,
  input  logic [mont_pkg::CTL_BITS-1:0]    i_ctl,
  output logic                             o_rdy,
  output logic                             o_val,
  output logic [mont_pkg::PROD_BITS-1:0]   o_dat,
  output logic [mont_pkg::CTL_BITS-1:0]    o_ctl,
  input  logic                             i_rdy
);
  import mont_pkg::*;

  logic [PROD_BITS-1:0] lo;
  logic [PROD_BITS-1:0] hi;
  logic [PROD_BITS-1:0] result;

  assign lo = i_dat[PROD_BITS-1:0];
  assign hi = i_dat[2*PROD_BITS-1:PROD_BITS];

  always_comb begin
    if (OP == OP_ADD) begin
      result = lo + hi;
    end else if (lo >= hi) begin
      result = lo - hi;
    end else begin
      result = lo;
    end
  end

  assign o_rdy = ~o_val || i_rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
    end else if (o_rdy) begin
      o_val <= i_val;
      o_dat <= result;
      o_ctl <= i_ctl;
    end
  end

endmodule

/* hdl/stream_mult.sv */
//====================================================================
// Stream multiplier
// Pipelined a*b over MULT_STAGES registers, tag travels alongside
//====================================================================
`timescale 1ns/1ps

module stream_mult (
  input  logic                           i_clk,
  input  logic                           i_rst,
  // Operands packed as {b, a}
  input  logic                           i_val,
  input  logic [mont_pkg::PROD_BITS-1:0] i_dat,
  input  logic [mont_pkg::CTL_BITS-1:0]  i_ctl,
  output logic                           o_rdy,
  output logic                           o_val,
  output logic [mont_pkg::PROD_BITS-1:0] o_dat,
  output logic [mont_pkg::CTL_BITS-1:0]  o_ctl,
  input  logic                           i_rdy
);
  import mont_pkg::*;

  localparam int HALF = DAT_BITS / 2;

  logic [MULT_STAGES-1:0]    val_q;
  logic [CTL_BITS-1:0]       ctl_q [MULT_STAGES];
  logic [DAT_BITS+HALF-1:0]  pp_lo_q;
  logic [DAT_BITS+HALF-1:0]  pp_hi_q;
  logic [PROD_BITS-1:0]      prod_q [1:MULT_STAGES-1];
  logic                      advance;

  // Whole pipe moves unless the last stage holds an untaken item
  assign advance = ~val_q[MULT_STAGES-1] || i_rdy;
  assign o_rdy   = advance;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      val_q <= '0;
    end else if (advance) begin
      val_q <= {val_q[MULT_STAGES-2:0], i_val};
    end
  end

  always_ff @(posedge i_clk) begin
    if (advance) begin
      // a times the low and high bytes of b
      pp_lo_q   <= i_dat[DAT_BITS-1:0] * i_dat[DAT_BITS +: HALF];
      pp_hi_q   <= i_dat[DAT_BITS-1:0] * i_dat[DAT_BITS+HALF +: HALF];
      ctl_q[0]  <= i_ctl;
      prod_q[1] <= PROD_BITS'(pp_lo_q) + (PROD_BITS'(pp_hi_q) << HALF);
      for (int s = 1; s < MULT_STAGES; s++) begin
        ctl_q[s] <= ctl_q[s-1];
      end
      for (int s = 2; s < MULT_STAGES; s++) begin
        prod_q[s] <= prod_q[s-1];
      end
    end
  end

  assign o_val = val_q[MULT_STAGES-1];
  assign o_dat = prod_q[MULT_STAGES-1];
  assign o_ctl = ctl_q[MULT_STAGES-1];

  // Stalled product stays put until the sink takes it
  assert property (@(posedge i_clk) disable iff (i_rst)
    o_val && !i_rdy |=> o_val && $stable(o_dat) && $stable(o_ctl));

endmodule

/* hdl/stream_fifo.sv */
//====================================================================
// Stream FIFO
// Circular buffer with valid/ready on both sides that holds T and its tag
//====================================================================
`timescale 1ns/1ps

module stream_fifo #(
  parameter int DEPTH = 16
) (
  input  logic                           i_clk,
  input  logic                           i_rst,
  input  logic                           i_val,
  input  logic [mont_pkg::PROD_BITS-1:0] i_dat,
  input  logic [mont_pkg::CTL_BITS-1:0]  i_ctl,
  output logic                           o_rdy,
  output logic                           o_val,
  output logic [mont_pkg::PROD_BITS-1:0] o_dat,
  output logic [mont_pkg::CTL_BITS-1:0]  o_ctl,
  input  logic                           i_rdy,
  output logic                           o_full
);
  import mont_pkg::*;

  localparam int PTR_BITS = $clog2(DEPTH);
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  logic [PROD_BITS-1:0] mem_dat [DEPTH];
  logic [CTL_BITS-1:0]  mem_ctl [DEPTH];
  logic [PTR_BITS-1:0]  wr_ptr_q;
  logic [PTR_BITS-1:0]  rd_ptr_q;
  logic [CNT_BITS-1:0]  count_q;
  logic                 wr_en;
  logic                 rd_en;

  assign o_full = (count_q == CNT_BITS'(DEPTH));
  assign o_rdy  = ~o_full;
  assign o_val  = (count_q != '0);
  // Head is read straight from the array
  assign o_dat  = mem_dat[rd_ptr_q];
  assign o_ctl  = mem_ctl[rd_ptr_q];
  assign wr_en  = i_val && o_rdy;
  assign rd_en  = o_val && i_rdy;

  always_ff @(posedge i_clk) begin
    if (wr_en) begin
      mem_dat[wr_ptr_q] <= i_dat;
      mem_ctl[wr_ptr_q] <= i_ctl;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Pointers meet only when the buffer is empty or full
  assert property (@(posedge i_clk) disable iff (i_rst)
    (wr_ptr_q == rd_ptr_q) == (count_q == '0 || o_full));

endmodule

/* hdl/mont_pkg.sv */
//====================================================================
// Montgomery multiplier package
// Widths, modulus constants and the arithmetic stage selector
//====================================================================
package mont_pkg;

  localparam int DAT_BITS    = 16;
  localparam int PROD_BITS   = 2 * DAT_BITS;
  localparam int CTL_BITS    = 8;
  localparam int REDUCE_BITS = 10;

  // Modulus and Montgomery constants, R = 2**REDUCE_BITS
  localparam logic [DAT_BITS-1:0] MOD_P       = 16'd251;
  // -P^-1 mod R, since 251 * 461 = 113 * 1024 - 1
  localparam logic [DAT_BITS-1:0] MONT_FACTOR = 16'd461;
  localparam logic [DAT_BITS-1:0] RED_MASK    = DAT_BITS'((1 << REDUCE_BITS) - 1);

  localparam int MULT_STAGES = 3;
  // At most eight items sit between the T write and the mP join
  localparam int FIFO_DEPTH  = 16;

  typedef enum logic {
    OP_ADD,
    OP_CSUB
  } addsub_op_t;

endpackage
